/* Bender.yml */
package:
  name: psg_wave

sources:
  - common/psgPkg.sv
  - hw/psgBusArb.sv
  - channel/waveChannel.sv
  - hw/waveTableRam.sv
  - hw/psgMixer.sv
  - hw/psgWaveTop.sv
  - target: simulation
    files:
      - verification/psgWaveChecker.sv
      - verification/psgWaveTb.sv

/* channel/waveChannel.sv */
`timescale 1ns/100ps

module waveChannel #(
	parameter int chanIndex = 0
) (
	input logic clk,
	input logic rst,
	input logic sampleTick,
	input psgPkg::hostWr_t hostWr,
	input psgPkg::fetchRsp_t rsp,
	output psgPkg::fetchReq_t fetch
);

	psgPkg::chanCfg_t cfg;
	logic cfgWr;
	logic ownAck;
	logic enable;
	logic [psgPkg::TableAddrBits-1:0] step;
	logic [psgPkg::TableAddrBits-1:0] addr;
	logic reqQ;

	// ========================================================================
	// decode
	// ========================================================================

	assign cfg = hostWr.word.chanCfg;

	assign cfgWr = hostWr.valid && !hostWr.isTable
		&& (hostWr.chan == psgPkg::ChanBits'(chanIndex));

	assign ownAck = rsp.ack && (rsp.chan == psgPkg::ChanBits'(chanIndex));

	// ========================================================================
	// config and table address
	// ========================================================================

	// a config write restarts the walk through the table at entry 0
	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			step <= '0;
			addr <= '0;
		end else if (cfgWr) begin
			enable <= cfg.enable;
			step <= cfg.step;
			addr <= '0;
		end else if (ownAck) begin
			// wraps around the 256 entry table
			addr <= addr + step;
		end
	end

	// ========================================================================
	// fetch request
	// ========================================================================

	// one request at most, a tick while pending is simply lost
	// the ack wins over a tick arriving on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			reqQ <= 1'b0;
		end else if (ownAck || (cfgWr && !cfg.enable)) begin
			reqQ <= 1'b0;
		end else if (sampleTick && enable) begin
			reqQ <= 1'b1;
		end
	end

	assign fetch.req = reqQ;
	assign fetch.addr = addr;

	// request only drops on its own ack, a disabling write or reset
	reqHeldToAck: assert property (
		@(posedge clk) disable iff (rst)
		$fell(reqQ) |-> ($past(ownAck) || $past(cfgWr && !cfg.enable) || $past(rst))
	) else $error("channel %0d dropped its request without an ack", chanIndex);

endmodule

/* common/psgPkg.sv */
package psgPkg;

	// ========================================================================
	// sizes
	// ========================================================================

	localparam int NumChannels = 4;
	localparam int ChanBits = 2;
	localparam int TableAddrBits = 8;
	localparam int SampleBits = 8;
	localparam int MixBits = 10;

	// cycles from read start to ack
	localparam int ReadLatency = 2;

	// ========================================================================
	// host write port
	// ========================================================================

	typedef struct packed {
		logic enable;
		logic [6:0] unused;
		logic [TableAddrBits-1:0] step;
	} chanCfg_t;

	typedef struct packed {
		logic [TableAddrBits-1:0] addr;
		logic [SampleBits-1:0] sample;
	} tableEntry_t;

	// one host word, decoded by isTable
	typedef union packed {
		chanCfg_t chanCfg;
		tableEntry_t tableEntry;
	} hostWord_u;

	typedef struct packed {
		logic valid;
		logic isTable;
		logic [ChanBits-1:0] chan;
		hostWord_u word;
	} hostWr_t;

	// ========================================================================
	// wave table read bus
	// ========================================================================

	typedef struct packed {
		logic req;
		logic [TableAddrBits-1:0] addr;
	} fetchReq_t;

	typedef struct packed {
		logic [NumChannels-1:0] sel;
		logic [ChanBits-1:0] seln;
	} grant_t;

	typedef struct packed {
		logic ack;
		logic [ChanBits-1:0] chan;
		logic [SampleBits-1:0] data;
	} fetchRsp_t;

endpackage

/* hw/psgBusArb.sv */
`timescale 1ns/100ps

module psgBusArb (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busFree,
	input logic [psgPkg::NumChannels-1:0] req,
	output psgPkg::grant_t grant
);

	psgPkg::grant_t nextGrant;

	// ========================================================================
	// fixed priority pick
	// ========================================================================

	// walk from the top down so the lowest requester wins
	// with no request at all the last owner stays on the bus
	always_comb begin
		nextGrant = grant;
		for (int i = psgPkg::NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextGrant.sel = '0;
				nextGrant.sel[i] = 1'b1;
				nextGrant.seln = i[psgPkg::ChanBits-1:0];
			end
		end
	end

	// re-arbitrate only on an enabled edge with the bus idle
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
		end else if (ce && busFree) begin
			grant <= nextGrant;
		end
	end

	// ========================================================================
	// checks
	// ========================================================================

	selOneHot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(grant.sel)
	) else $error("arbiter select is not one-hot");

	selMatchesIndex: assert property (
		@(posedge clk) disable iff (rst)
		(grant.sel == '0) || grant.sel[grant.seln]
	) else $error("arbiter select and index disagree");

	// a busy bus or a stalled clock enable freezes the owner
	holdWhenBlocked: assert property (
		@(posedge clk) disable iff (rst)
		(!ce || !busFree) |=> $stable(grant)
	) else $error("grant changed while bus busy or ce low");

endmodule

/* hw/psgMixer.sv */
`timescale 1ns/100ps

module psgMixer (
	input logic clk,
	input logic rst,
	input psgPkg::fetchRsp_t rsp,
	output logic signed [psgPkg::MixBits-1:0] mixOut
);

	logic signed [psgPkg::SampleBits-1:0] slot [psgPkg::NumChannels];
	logic signed [psgPkg::SampleBits-1:0] nextSlot [psgPkg::NumChannels];
	logic signed [psgPkg::MixBits-1:0] nextSum;

	// ========================================================================
	// slot update and sum
	// ========================================================================

	// the new sample is already part of the sum on the same edge
	always_comb begin
		nextSlot = slot;
		if (rsp.ack) begin
			nextSlot[rsp.chan] = rsp.data;
		end
		nextSum = '0;
		for (int i = 0; i < psgPkg::NumChannels; i++) begin
			// sign extended to the mix width
			nextSum = nextSum + nextSlot[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '{default: '0};
			mixOut <= '0;
		end else if (rsp.ack) begin
			slot <= nextSlot;
			mixOut <= nextSum;
		end
	end

endmodule

/* hw/psgWaveTop.sv */
`timescale 1ns/100ps

module psgWaveTop (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic sampleTick,
	input psgPkg::hostWr_t hostWr,
	output psgPkg::fetchRsp_t rsp,
	output logic signed [psgPkg::MixBits-1:0] mixOut
);

	psgPkg::fetchReq_t fetch [psgPkg::NumChannels];
	logic [psgPkg::NumChannels-1:0] req;
	psgPkg::grant_t grant;
	logic busFree;

	// ========================================================================
	// wave channels
	// ========================================================================

	for (genvar i = 0; i < psgPkg::NumChannels; i++) begin : gChan
		waveChannel #(
			.chanIndex(i)
		) u_waveChannel (
			.clk(clk),
			.rst(rst),
			.sampleTick(sampleTick),
			.hostWr(hostWr),
			.rsp(rsp),
			.fetch(fetch[i])
		);

		assign req[i] = fetch[i].req;
	end

	// ========================================================================
	// shared read bus
	// ========================================================================

	psgBusArb u_psgBusArb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busFree(busFree),
		.req(req),
		.grant(grant)
	);

	waveTableRam u_waveTableRam (
		.clk(clk),
		.rst(rst),
		.hostWr(hostWr),
		.grant(grant),
		.fetch(fetch),
		.busFree(busFree),
		.rsp(rsp)
	);

	// mixer output
	psgMixer u_psgMixer (
		.clk(clk),
		.rst(rst),
		.rsp(rsp),
		.mixOut(mixOut)
	);

endmodule

/* hw/waveTableRam.sv */
`timescale 1ns/100ps

module waveTableRam (
	input logic clk,
	input logic rst,
	input psgPkg::hostWr_t hostWr,
	input psgPkg::grant_t grant,
	input psgPkg::fetchReq_t fetch [psgPkg::NumChannels],
	output logic busFree,
	output psgPkg::fetchRsp_t rsp
);

	logic [psgPkg::SampleBits-1:0] mem [2**psgPkg::TableAddrBits];
	logic ownerReq;
	logic startRead;
	logic busy;
	logic [$clog2(psgPkg::ReadLatency + 1)-1:0] cnt;
	logic ackQ;
	logic [psgPkg::ChanBits-1:0] rdChan;
	logic [psgPkg::TableAddrBits-1:0] rdAddr;
	logic [psgPkg::SampleBits-1:0] rdData;

	// host loads the table through the entry view
	always_ff @(posedge clk) begin
		if (hostWr.valid && hostWr.isTable) begin
			mem[hostWr.word.tableEntry.addr] <= hostWr.word.tableEntry.sample;
		end
	end

	// ========================================================================
	// read engine
	// ========================================================================

	assign ownerReq = grant.sel[grant.seln] && fetch[grant.seln].req;
	assign startRead = !busy && ownerReq;
	assign busFree = !busy && !ownerReq;

	// busy covers the ack cycle too since the owner drops req on that edge
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			ackQ <= 1'b0;
		end else begin
			ackQ <= 1'b0;
			if (startRead) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				if (ackQ) begin
					busy <= 1'b0;
				end else if (cnt == psgPkg::ReadLatency - 1) begin
					ackQ <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// owner and address are latched at start
	always_ff @(posedge clk) begin
		if (startRead) begin
			rdChan <= grant.seln;
			rdAddr <= fetch[grant.seln].addr;
		end
		if (busy) begin
			rdData <= mem[rdAddr];
		end
	end

	assign rsp = '{ack: ackQ, chan: rdChan, data: rdData};

	// ack rises ReadLatency edges after the start edge
	startToAck: assert property (
		@(posedge clk) disable iff (rst)
		startRead |=> ##(psgPkg::ReadLatency) rsp.ack
	) else $error("read ack not at fixed latency");

	noOverlap: assert property (
		@(posedge clk) disable iff (rst)
		startRead |=> !startRead [*(psgPkg::ReadLatency + 1)]
	) else $error("read started while engine busy");

endmodule

/* verification/psgWaveChecker.sv */
`timescale 1ns/100ps

module psgWaveChecker (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic sampleTick,
	input psgPkg::hostWr_t hostWr,
	input psgPkg::fetchRsp_t rsp,
	input logic signed [psgPkg::MixBits-1:0] mixOut,
	output int errorCount,
	output int ackCount
);

	logic [psgPkg::SampleBits-1:0] shadow [2**psgPkg::TableAddrBits];
	logic mEn [psgPkg::NumChannels];
	logic mReq [psgPkg::NumChannels];
	logic [psgPkg::TableAddrBits-1:0] mStep [psgPkg::NumChannels];
	logic [psgPkg::TableAddrBits-1:0] mAddr [psgPkg::NumChannels];
	logic signed [psgPkg::SampleBits-1:0] mSlot [psgPkg::NumChannels];
	logic signed [psgPkg::MixBits-1:0] mMix;
	logic ownerValid;
	logic busy;
	int owner;
	int age;
	int rdChan;
	logic [psgPkg::TableAddrBits-1:0] rdAddr;
	int errors = 0;
	int acks = 0;
	int resetEdges = 0;

	assign errorCount = errors;
	assign ackCount = acks;

	task automatic reportError(input string msg);
		errors++;
		$display("ERROR @%0t: %s", $time, msg);
	endtask

	// ========================================================================
	// cycle model, sampled at the rising edge
	// ========================================================================

	always @(posedge clk) begin : modelStep
		logic expectAck;
		logic ownerReq;
		logic busFree;
		logic cfgWr;
		logic ownAck;
		logic [psgPkg::SampleBits-1:0] expData;
		logic signed [psgPkg::MixBits-1:0] sum;
		int pick;

		// the ack is visible ReadLatency edges after the start edge
		expectAck = busy && (age == psgPkg::ReadLatency);
		expData = shadow[rdAddr];

		if (resetEdges > 0) begin
			if (rsp.ack !== expectAck) begin
				reportError($sformatf("ack is %b, model expects %b", rsp.ack, expectAck));
			end else if (expectAck) begin
				acks++;
				if (rsp.chan !== psgPkg::ChanBits'(rdChan)) begin
					reportError($sformatf("ack for channel %0d, expected channel %0d",
						rsp.chan, rdChan));
				end
				if (rsp.data !== expData) begin
					reportError($sformatf("channel %0d addr %0d data %h, expected %h",
						rdChan, rdAddr, rsp.data, expData));
				end
			end
			if (mixOut !== mMix) begin
				reportError($sformatf("mixOut %0d, expected %0d", mixOut, mMix));
			end
		end

		if (rst) begin
			for (int c = 0; c < psgPkg::NumChannels; c++) begin
				mEn[c] = 1'b0;
				mReq[c] = 1'b0;
				mStep[c] = '0;
				mAddr[c] = '0;
				mSlot[c] = '0;
			end
			mMix = '0;
			ownerValid = 1'b0;
			owner = 0;
			busy = 1'b0;
			age = 0;
			resetEdges++;
		end else begin
			ownerReq = ownerValid && mReq[owner];
			busFree = !busy && !ownerReq;

			// mixer takes the sample of the acked channel
			if (expectAck) begin
				mSlot[rdChan] = expData;
				sum = '0;
				for (int c = 0; c < psgPkg::NumChannels; c++) begin
					sum = sum + mSlot[c];
				end
				mMix = sum;
			end

			// single read in flight, started for the current owner
			if (busy) begin
				if (age == psgPkg::ReadLatency) begin
					busy = 1'b0;
				end else begin
					age++;
				end
			end else if (ownerReq) begin
				busy = 1'b1;
				age = 0;
				rdChan = owner;
				rdAddr = mAddr[owner];
			end

			// lowest pending index wins on a free bus with ce high
			if (ce && busFree) begin
				pick = -1;
				for (int c = psgPkg::NumChannels - 1; c >= 0; c--) begin
					if (mReq[c]) begin
						pick = c;
					end
				end
				if (pick >= 0) begin
					ownerValid = 1'b1;
					owner = pick;
				end
			end

			for (int c = 0; c < psgPkg::NumChannels; c++) begin
				cfgWr = hostWr.valid && !hostWr.isTable
					&& (hostWr.chan == psgPkg::ChanBits'(c));
				ownAck = expectAck && (rdChan == c);
				if (ownAck || (cfgWr && !hostWr.word.chanCfg.enable)) begin
					mReq[c] = 1'b0;
				end else if (sampleTick && mEn[c]) begin
					mReq[c] = 1'b1;
				end
				if (cfgWr) begin
					mEn[c] = hostWr.word.chanCfg.enable;
					mStep[c] = hostWr.word.chanCfg.step;
					mAddr[c] = '0;
				end else if (ownAck) begin
					mAddr[c] = mAddr[c] + mStep[c];
				end
			end
		end

		if (hostWr.valid && hostWr.isTable) begin
			shadow[hostWr.word.tableEntry.addr] = hostWr.word.tableEntry.sample;
		end
	end

endmodule

/* verification/psgWaveTb.sv */
`timescale 1ns/100ps

module psgWaveTb;

	localparam int TickPeriod = 16;
	localparam int NumTicks = 64;
	localparam int QuietCycles = 24;
	localparam int DrainTimeout = 400;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	logic sampleTick;
	psgPkg::hostWr_t hostWr;
	psgPkg::fetchRsp_t rsp;
	logic signed [psgPkg::MixBits-1:0] mixOut;
	int errorCount;
	int ackCount;
	int timeoutCount = 0;
	int ceLowLeft = 0;
	logic [31:0] rngState = 32'd63;

	always #5 clk = ~clk;

	psgWaveTop u_psgWaveTop (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sampleTick(sampleTick),
		.hostWr(hostWr),
		.rsp(rsp),
		.mixOut(mixOut)
	);

	psgWaveChecker u_psgWaveChecker (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sampleTick(sampleTick),
		.hostWr(hostWr),
		.rsp(rsp),
		.mixOut(mixOut),
		.errorCount(errorCount),
		.ackCount(ackCount)
	);

	// ========================================================================
	// stimulus helpers
	// ========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRandom(output logic [31:0] r);
		rngState = xorshift32(rngState);
		r = rngState;
	endtask

	// one host write, valid for a single cycle
	task automatic hostWrite(input logic isTable, input logic [psgPkg::ChanBits-1:0] chan,
		input psgPkg::hostWord_u word);
		@(negedge clk);
		hostWr.valid = 1'b1;
		hostWr.isTable = isTable;
		hostWr.chan = chan;
		hostWr.word = word;
		@(negedge clk);
		hostWr.valid = 1'b0;
	endtask

	task automatic configureChannels();
		logic [31:0] r;
		logic anyEnabled;
		psgPkg::hostWord_u word;
		anyEnabled = 1'b0;
		for (int c = 0; c < psgPkg::NumChannels; c++) begin
			nextRandom(r);
			// last channel is forced on if nobody else is
			word.chanCfg.enable = r[0] | r[1] | (c == psgPkg::NumChannels - 1 && !anyEnabled);
			word.chanCfg.unused = '0;
			word.chanCfg.step = r[15:8];
			anyEnabled = anyEnabled | word.chanCfg.enable;
			hostWrite(1'b0, psgPkg::ChanBits'(c), word);
		end
	endtask

	// ce drops now and then for a random stretch
	task automatic driveCycle(input logic tick);
		logic [31:0] r;
		@(negedge clk);
		sampleTick = tick;
		if (ceLowLeft > 0) begin
			ce = 1'b0;
			ceLowLeft--;
		end else begin
			nextRandom(r);
			ce = (r[4:0] != 5'd0);
			if (r[4:0] == 5'd0) begin
				ceLowLeft = 3 + int'(r[10:5]);
			end
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin : stimulus
		logic [31:0] r;
		psgPkg::hostWord_u word;
		int quiet;
		int waited;
		rst = 1'b1;
		ce = 1'b0;
		sampleTick = 1'b0;
		hostWr = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		for (int a = 0; a < 2**psgPkg::TableAddrBits; a++) begin
			nextRandom(r);
			word.tableEntry.addr = psgPkg::TableAddrBits'(a);
			word.tableEntry.sample = r[psgPkg::SampleBits-1:0];
			hostWrite(1'b1, '0, word);
		end

		configureChannels();

		ce = 1'b1;
		for (int t = 0; t < NumTicks; t++) begin
			if (t == NumTicks / 2) begin
				configureChannels();
			end
			driveCycle(1'b1);
			repeat (TickPeriod - 1) driveCycle(1'b0);
		end

		// let the pending reads drain with ce high
		@(negedge clk);
		ce = 1'b1;
		sampleTick = 1'b0;
		quiet = 0;
		waited = 0;
		while (quiet < QuietCycles && waited < DrainTimeout) begin
			@(negedge clk);
			waited++;
			quiet = rsp.ack ? 0 : quiet + 1;
		end
		if (quiet < QuietCycles) begin
			timeoutCount++;
			$display("reads were still completing when the drain limit ran out");
		end
		if (ackCount == 0) begin
			$display("no read acknowledge was seen during the whole run");
		end

		$display("acks %0d, errors %0d, timeouts %0d", ackCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && ackCount > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
common/psgPkg.sv
hw/psgBusArb.sv
channel/waveChannel.sv
hw/waveTableRam.sv
hw/psgMixer.sv
hw/psgWaveTop.sv
verification/psgWaveChecker.sv
verification/psgWaveTb.sv
